// File: tests/pet_input.txt
# test target food ball broom pills first_aid hungry bored dirty sick dying deceased sleeping age
# target 0 resets the pet; care levels hold from the start of a line until the next line
1  15  0 1 1 1 0  1 0 0 0 0 0 0 0
2  16  1 1 1 1 0  0 0 0 0 0 0 0 0
3  44  0 1 1 1 0  1 0 0 0 0 0 1 0
4  100 0 1 1 1 0  1 0 0 0 0 0 1 0
5  140 0 1 1 1 0  1 0 0 0 0 0 0 1
6  150 0 1 1 1 0  1 0 0 0 0 0 0 1
7  156 0 1 1 1 0  0 0 0 0 1 0 0 1
8  160 1 1 1 1 1  0 0 0 0 0 0 0 1
# neglected pet
9  0   0 0 0 0 0  0 0 0 0 0 0 0 0
10 30  0 0 0 0 0  1 1 1 1 0 0 0 0
11 44  0 0 0 0 0  0 0 0 0 1 0 0 0
12 250 0 0 0 0 0  0 0 0 0 1 0 0 0
13 252 0 0 0 0 0  0 0 0 0 0 1 0 0
# well cared for pet, dies of old age
14 0   1 1 1 1 0  0 0 0 0 0 0 0 0
15 200 1 1 1 1 0  0 0 0 0 0 0 1 1
16 330 1 1 1 1 0  0 0 0 0 0 1 0 2

// File: compile.f
+incdir+verilog
verilog/pet_pkg.sv
verilog/life_clock.sv
verilog/need_tracker.sv
verilog/vital_monitor.sv
verilog/sleep_cycle.sv
verilog/pet_status_top.sv
tests/pet_status_tb.sv

// File: tests/pet_status_tb.sv
module pet_status_tb;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int TICK_CYCLES  = 4;
    localparam int CLK_PERIOD   = 100;
    localparam int RESET_CYCLES = 8;
    localparam int MAX_TESTS    = 64;
    localparam int NUM_FIELDS   = 15;

    // column positions in a test line
    localparam int COL_TEST   = 0;
    localparam int COL_TARGET = 1;
    localparam int COL_CARE   = 2;
    localparam int COL_EXPECT = 7;

    // a dead pet is watched this long for a moving count
    localparam int HOLD_CYCLES = 3 * TICK_CYCLES;
    localparam int LINE_MARGIN = 40;

    logic                 clk;
    logic                 reset;
    logic                 food;
    logic                 ball;
    logic                 broom;
    logic                 pills;
    logic                 first_aid;
    logic                 hungry;
    logic                 bored;
    logic                 dirty;
    logic                 sick;
    logic                 dying;
    logic                 deceased;
    logic                 sleeping;
    pet_pkg::age_t        age;
    pet_pkg::life_count_t life_count;

    int     tests [MAX_TESTS][NUM_FIELDS];
    int     num_tests;
    int     current_test;
    int     errors;
    int     tests_passed;
    int     tests_failed;
    longint watchdog_ns;
    logic   watchdog_armed;

    pet_status_top #(
        .TICK_CYCLES(TICK_CYCLES)
    ) UUT (
        .clk       (clk),
        .reset     (reset),
        .food      (food),
        .ball      (ball),
        .broom     (broom),
        .pills     (pills),
        .first_aid (first_aid),
        .hungry    (hungry),
        .bored     (bored),
        .dirty     (dirty),
        .sick      (sick),
        .dying     (dying),
        .deceased  (deceased),
        .sleeping  (sleeping),
        .age       (age),
        .life_count(life_count)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic apply_reset();
        reset <= 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;
    endtask

    task automatic read_tests(output logic ok);
        int    fd;
        int    n;
        string line;
        num_tests = 0;
        fd = $fopen("tests/pet_input.txt", "r");
        if (fd != 0) begin
            while (!$feof(fd) && num_tests < MAX_TESTS) begin
                line = "";
                n = $fgets(line, fd);
                // comment lines carry no test
                if (n > 0 && line.getc(0) != "#") begin
                    n = $sscanf(line, "%d %d %d %d %d %d %d %d %d %d %d %d %d %d %d",
                        tests[num_tests][0], tests[num_tests][1], tests[num_tests][2],
                        tests[num_tests][3], tests[num_tests][4], tests[num_tests][5],
                        tests[num_tests][6], tests[num_tests][7], tests[num_tests][8],
                        tests[num_tests][9], tests[num_tests][10], tests[num_tests][11],
                        tests[num_tests][12], tests[num_tests][13], tests[num_tests][14]);
                    if (n == NUM_FIELDS) begin
                        num_tests++;
                    end
                end
            end
            $fclose(fd);
        end
        ok = (num_tests > 0);
    endtask

    // ticks needed to walk through every target, restarting at each reset line
    function automatic longint timeout_from_targets();
        longint ticks;
        int     last_target;
        int     i;
        ticks = 0;
        last_target = 0;
        for (i = 0; i < num_tests; i++) begin
            if (tests[i][COL_TARGET] > last_target) begin
                ticks += tests[i][COL_TARGET] - last_target;
            end
            last_target = tests[i][COL_TARGET];
        end
        return (ticks * TICK_CYCLES + (num_tests + 1) * LINE_MARGIN) * CLK_PERIOD;
    endfunction

    task automatic check_value(
        input string       name,
        input logic [31:0] actual,
        input logic [31:0] expected
    );
        assert (actual === expected)
        else begin
            $display("ERROR at %0t ns: %s expected %0d, got %0d",
                $time, name, expected, actual);
            errors++;
        end
    endtask

    task automatic compare_status(input int idx);
        check_value("hungry", hungry, tests[idx][COL_EXPECT]);
        check_value("bored", bored, tests[idx][COL_EXPECT + 1]);
        check_value("dirty", dirty, tests[idx][COL_EXPECT + 2]);
        check_value("sick", sick, tests[idx][COL_EXPECT + 3]);
        check_value("dying", dying, tests[idx][COL_EXPECT + 4]);
        check_value("deceased", deceased, tests[idx][COL_EXPECT + 5]);
        check_value("sleeping", sleeping, tests[idx][COL_EXPECT + 6]);
        check_value("age", age, tests[idx][COL_EXPECT + 7]);
        check_value("life_count", life_count, tests[idx][COL_TARGET]);
    endtask

    task automatic run_test(input int idx);
        int errors_before;
        int target;
        target = tests[idx][COL_TARGET];
        errors_before = errors;
        current_test = tests[idx][COL_TEST];
        @(posedge clk);
        food      <= (tests[idx][COL_CARE] != 0);
        ball      <= (tests[idx][COL_CARE + 1] != 0);
        broom     <= (tests[idx][COL_CARE + 2] != 0);
        pills     <= (tests[idx][COL_CARE + 3] != 0);
        first_aid <= (tests[idx][COL_CARE + 4] != 0);
        // target 0 starts a fresh pet
        if (target == 0) begin
            apply_reset();
        end
        do begin
            @(negedge clk);
        end while (life_count !== target);
        // status settles one cycle after the tick
        repeat (2) @(negedge clk);
        compare_status(idx);
        if (tests[idx][COL_EXPECT + 5] != 0) begin
            // count must stay frozen once dead
            repeat (HOLD_CYCLES) @(negedge clk);
            check_value("life_count", life_count, target);
        end
        if (errors == errors_before) begin
            tests_passed++;
            $display("test %0d at life count %0d: pass", current_test, target);
        end else begin
            tests_failed++;
            $display("test %0d at life count %0d: fail, %0d mismatches",
                current_test, target, errors - errors_before);
        end
    endtask

    initial begin
        logic ok;
        int   i;
        reset          = 1'b1;
        food           = 1'b0;
        ball           = 1'b0;
        broom          = 1'b0;
        pills          = 1'b0;
        first_aid      = 1'b0;
        errors         = 0;
        tests_passed   = 0;
        tests_failed   = 0;
        current_test   = 0;
        watchdog_armed = 1'b0;
        read_tests(ok);
        if (!ok) begin
            $display("could not read any test from tests/pet_input.txt");
            $display("Errors found");
            $finish;
        end else begin
            watchdog_ns = timeout_from_targets();
            watchdog_armed = 1'b1;
            apply_reset();
            for (i = 0; i < num_tests; i++) begin
                run_test(i);
            end
            $display("%0d tests passed, %0d tests failed", tests_passed, tests_failed);
            if (tests_failed == 0) begin
                $display("No errors");
            end else begin
                $display("Errors found");
            end
            $finish;
        end
    end

    // watchdog
    initial begin
        wait (watchdog_armed === 1'b1);
        #(watchdog_ns);
        $display("run timed out after %0d ns, stuck in test %0d", watchdog_ns, current_test);
        $display("Errors found");
        $finish;
    end

endmodule

// File: verilog/pet_status_top.sv
`include "pet_macros.svh"

module pet_status_top #(
    parameter int TICK_CYCLES = `PET_TICK_CYCLES
) (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 food,
    input  logic                 ball,
    input  logic                 broom,
    input  logic                 pills,
    input  logic                 first_aid,
    output logic                 hungry,
    output logic                 bored,
    output logic                 dirty,
    output logic                 sick,
    output logic                 dying,
    output logic                 deceased,
    output logic                 sleeping,
    output pet_pkg::age_t        age,
    output pet_pkg::life_count_t life_count
);

    logic       tick;
    logic       old_age;
    // hunger, bored, dirty, sick from bit 0 up
    logic [3:0] dying_request;

    life_clock #(
        .TICK_CYCLES(TICK_CYCLES)
    ) u_life_clock (
        .clk       (clk),
        .reset     (reset),
        .deceased  (deceased),
        .tick      (tick),
        .life_count(life_count),
        .old_age   (old_age)
    );

    need_tracker #(
        .ONSET_MASK    (`PET_HUNGER_MASK),
        .ONSET_VALUE   (`PET_HUNGER_ONSET),
        .ESCALATE_VALUE(`PET_NEED_ESCALATE)
    ) u_hunger (
        .clk          (clk),
        .reset        (reset),
        .tick         (tick),
        .life_count   (life_count),
        .care         (food),
        .sleeping     (sleeping),
        .dying        (dying),
        .deceased     (deceased),
        .need         (hungry),
        .dying_request(dying_request[0])
    );

    need_tracker #(
        .ONSET_MASK    (`PET_BORED_MASK),
        .ONSET_VALUE   (`PET_BORED_ONSET),
        .ESCALATE_VALUE(`PET_NEED_ESCALATE)
    ) u_bored (
        .clk          (clk),
        .reset        (reset),
        .tick         (tick),
        .life_count   (life_count),
        .care         (ball),
        .sleeping     (sleeping),
        .dying        (dying),
        .deceased     (deceased),
        .need         (bored),
        .dying_request(dying_request[1])
    );

    need_tracker #(
        .ONSET_MASK    (`PET_DIRTY_MASK),
        .ONSET_VALUE   (`PET_DIRTY_ONSET),
        .ESCALATE_VALUE(`PET_NEED_ESCALATE)
    ) u_dirty (
        .clk          (clk),
        .reset        (reset),
        .tick         (tick),
        .life_count   (life_count),
        .care         (broom),
        .sleeping     (sleeping),
        .dying        (dying),
        .deceased     (deceased),
        .need         (dirty),
        .dying_request(dying_request[2])
    );

    // sickness escalates on its own beat
    need_tracker #(
        .ONSET_MASK    (`PET_SICK_MASK),
        .ONSET_VALUE   (`PET_SICK_ONSET),
        .ESCALATE_VALUE(`PET_SICK_ESCALATE)
    ) u_sick (
        .clk          (clk),
        .reset        (reset),
        .tick         (tick),
        .life_count   (life_count),
        .care         (pills),
        .sleeping     (sleeping),
        .dying        (dying),
        .deceased     (deceased),
        .need         (sick),
        .dying_request(dying_request[3])
    );

    vital_monitor u_vital_monitor (
        .clk          (clk),
        .reset        (reset),
        .tick         (tick),
        .life_count   (life_count),
        .dying_request(dying_request),
        .first_aid    (first_aid),
        .old_age      (old_age),
        .dying        (dying),
        .deceased     (deceased)
    );

    sleep_cycle u_sleep_cycle (
        .clk       (clk),
        .reset     (reset),
        .tick      (tick),
        .life_count(life_count),
        .dying     (dying),
        .deceased  (deceased),
        .sleeping  (sleeping),
        .age       (age)
    );

endmodule

// File: verilog/sleep_cycle.sv
`include "pet_macros.svh"

module sleep_cycle (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 tick,
    input  pet_pkg::life_count_t life_count,
    input  logic                 dying,
    input  logic                 deceased,
    output logic                 sleeping,
    output pet_pkg::age_t        age
);

    localparam pet_pkg::sleep_count_t LAST_STEP = `PET_SLEEP_LENGTH - 4'd1;

    pet_pkg::sleep_count_t sleep_steps;
    logic                  onset_tick;
    logic                  step_tick;

    assign onset_tick = tick &&
        pet_pkg::count_match(life_count, `PET_SLEEP_MASK, `PET_SLEEP_ONSET);

    assign step_tick = tick &&
        pet_pkg::count_match(life_count, `PET_SLEEP_STEP_MASK, `PET_SLEEP_STEP);

    always_ff @(posedge clk) begin
        if (reset) begin
            sleeping    <= 1'b0;
            sleep_steps <= '0;
            age         <= '0;
        end else if (dying || deceased) begin
            sleeping    <= 1'b0;
            sleep_steps <= '0;
        end else if (!sleeping) begin
            if (onset_tick) begin
                sleeping <= 1'b1;
            end
        end else if (step_tick) begin
            if (sleep_steps == LAST_STEP) begin
                // wake up one age step older
                sleeping    <= 1'b0;
                sleep_steps <= '0;
                age         <= age + 1'b1;
            end else begin
                sleep_steps <= sleep_steps + 1'b1;
            end
        end
    end

endmodule

// File: verilog/vital_monitor.sv
`include "pet_macros.svh"

module vital_monitor (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 tick,
    input  pet_pkg::life_count_t life_count,
    input  logic [3:0]           dying_request,
    input  logic                 first_aid,
    input  logic                 old_age,
    output logic                 dying,
    output logic                 deceased
);

    localparam pet_pkg::step_count_t LAST_STEP = `PET_STEP_LIMIT - 3'd1;

    pet_pkg::step_count_t dead_steps;
    logic                 dying_tick;

    assign dying_tick = tick &&
        pet_pkg::count_match(life_count, `PET_DYING_MASK, `PET_DYING_STEP);

    always_ff @(posedge clk) begin
        if (reset) begin
            dying      <= 1'b0;
            deceased   <= 1'b0;
            dead_steps <= '0;
        end else if (!deceased) begin
            if (old_age) begin
                deceased <= 1'b1;
                dying    <= 1'b0;
            end else if (dying && dying_tick && dead_steps == LAST_STEP) begin
                // seventh step ends it
                dead_steps <= dead_steps + 1'b1;
                deceased   <= 1'b1;
                dying      <= 1'b0;
            end else begin
                if (first_aid) begin
                    dying <= 1'b0;
                end else if (|dying_request) begin
                    dying <= 1'b1;
                end
                // first aid does not rewind the dying steps
                if (dying && dying_tick) begin
                    dead_steps <= dead_steps + 1'b1;
                end
            end
        end
    end

endmodule

// File: verilog/need_tracker.sv
`include "pet_macros.svh"

module need_tracker #(
    parameter pet_pkg::life_count_t ONSET_MASK     = `PET_HUNGER_MASK,
    parameter pet_pkg::life_count_t ONSET_VALUE    = `PET_HUNGER_ONSET,
    parameter pet_pkg::life_count_t ESCALATE_VALUE = `PET_NEED_ESCALATE
) (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 tick,
    input  pet_pkg::life_count_t life_count,
    input  logic                 care,
    input  logic                 sleeping,
    input  logic                 dying,
    input  logic                 deceased,
    output logic                 need,
    output logic                 dying_request
);

    pet_pkg::step_count_t steps;
    logic                 onset_tick;
    logic                 escalate_tick;
    logic                 at_limit;

    assign onset_tick = tick &&
        pet_pkg::count_match(life_count, ONSET_MASK, ONSET_VALUE);

    assign escalate_tick = tick &&
        pet_pkg::count_match(life_count, `PET_ESCALATE_MASK, ESCALATE_VALUE);

    assign at_limit = (steps == `PET_STEP_LIMIT);

    always_ff @(posedge clk) begin
        if (reset) begin
            need  <= 1'b0;
            steps <= '0;
        end else if (care) begin
            need  <= 1'b0;
            steps <= '0;
        end else if (dying || deceased) begin
            need <= 1'b0;
        end else if (!sleeping) begin
            if (!need) begin
                if (onset_tick) begin
                    need  <= 1'b1;
                    // a fresh need starts its escalation from zero
                    steps <= '0;
                end
            end else if (escalate_tick && !at_limit) begin
                steps <= steps + 1'b1;
            end
        end
        // asleep: need and steps hold
    end

    // neglected long enough
    assign dying_request = need && at_limit;

endmodule

// File: verilog/life_clock.sv
`include "pet_macros.svh"

module life_clock #(
    parameter int TICK_CYCLES = `PET_TICK_CYCLES
) (
    input  logic                clk,
    input  logic                reset,
    input  logic                deceased,
    output logic                tick,
    output pet_pkg::life_count_t life_count,
    output logic                old_age
);

    localparam int CNT_W = $clog2(TICK_CYCLES + 1);
    localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(TICK_CYCLES - 1);

    logic [CNT_W-1:0] cycle_cnt;
    logic             running;

    // stops once the pet is gone or has reached its lifespan
    assign running = !deceased && !old_age;

    always_ff @(posedge clk) begin
        if (reset) begin
            cycle_cnt  <= '0;
            tick       <= 1'b0;
            life_count <= '0;
        end else if (running) begin
            if (cycle_cnt == CNT_LAST) begin
                cycle_cnt  <= '0;
                tick       <= 1'b1;
                // new count is visible together with the tick
                life_count <= life_count + 1'b1;
            end else begin
                cycle_cnt <= cycle_cnt + 1'b1;
                tick      <= 1'b0;
            end
        end else begin
            tick <= 1'b0;
        end
    end

    assign old_age = (life_count == `PET_MAX_LIFESPAN);

endmodule

// File: verilog/pet_pkg.sv
package pet_pkg;

    // elapsed ticks since reset
    typedef logic [8:0] life_count_t;

    // escalation and dying-to-dead steps, 7 is the trigger
    typedef logic [2:0] step_count_t;

    // completed sleeps
    typedef logic [3:0] age_t;

    typedef logic [3:0] sleep_count_t;

    // a count of zero never matches
    function automatic logic count_match(
        life_count_t count,
        life_count_t mask,
        life_count_t value
    );
        logic nonzero;
        logic masked_equal;
        nonzero = (count != '0);
        masked_equal = ((count & mask) == value);
        return nonzero && masked_equal;
    endfunction

endpackage

// File: verilog/pet_macros.svh
`ifndef PET_MACROS_SVH
`define PET_MACROS_SVH

// life clock
`define PET_MAX_LIFESPAN     9'd330
`define PET_TICK_CYCLES      50_000_000

// need onset points, compared under their masks
`define PET_HUNGER_ONSET     9'd15
`define PET_HUNGER_MASK      9'h00f
`define PET_BORED_ONSET      9'd19
`define PET_BORED_MASK       9'h01f
`define PET_DIRTY_ONSET      9'd24
`define PET_DIRTY_MASK       9'h01f
`define PET_SICK_ONSET       9'd29
`define PET_SICK_MASK        9'h01f

// escalation of an unanswered need
`define PET_ESCALATE_MASK    9'h003
`define PET_NEED_ESCALATE    9'd2
`define PET_SICK_ESCALATE    9'd3
`define PET_STEP_LIMIT       3'd7

// dying to dead
`define PET_DYING_STEP       9'd28
`define PET_DYING_MASK       9'h01f

// sleep, once per 64 ticks
`define PET_SLEEP_ONSET      9'd44
`define PET_SLEEP_MASK       9'h03f
`define PET_SLEEP_STEP       9'd4
`define PET_SLEEP_STEP_MASK  9'h007
`define PET_SLEEP_LENGTH     4'd12

`endif
